// File: compile.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_top.sv
verification/tb_mips_top.sv

// File: verification/tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top;

    localparam mips_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    logic            clk;
    logic            reset_i;
    mips_pkg::word_t inst_sram_addr;
    mips_pkg::word_t inst_sram_rdata;
    logic [3:0]      data_sram_wen;
    mips_pkg::word_t data_sram_addr;
    mips_pkg::word_t data_sram_wdata;
    mips_pkg::word_t data_sram_rdata;

    mips_pkg::word_t imem [IMEM_WORDS];
    mips_pkg::word_t dmem [DMEM_WORDS];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];
    int              prog_len = 0;
    int              first_lw = -1;
    int              cycles = 0;
    int              seen = 0;
    int              timeout_limit;
    logic [15:0]     store_off = 16'h0100;

    mips_top #(
        .RESET_PC(RESET_PC)
    ) dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_sram_addr_o (inst_sram_addr),
        .inst_sram_rdata_i(inst_sram_rdata),
        .data_sram_wen_o  (data_sram_wen),
        .data_sram_addr_o (data_sram_addr),
        .data_sram_wdata_o(data_sram_wdata),
        .data_sram_rdata_i(data_sram_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // fetch past the program sees zero words which are nops
    assign inst_sram_rdata = (inst_sram_addr[31:2] < IMEM_WORDS) ?
                             imem[inst_sram_addr[9:2]] : '0;
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_wen != 4'h0) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    function automatic mips_pkg::word_t fill_word(input int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ (idx << 20);
    endfunction

    function automatic mips_pkg::word_t r_type(input mips_pkg::funct_e fn,
            input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
            input mips_pkg::reg_addr_t rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t i_type(input mips_pkg::opcode_e op,
            input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs,
            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic emit(input mips_pkg::word_t w);
        imem[prog_len] = w;
        if (w[31:26] == mips_pkg::OP_LW && first_lw < 0) begin
            first_lw = prog_len;
        end
        prog_len++;
    endtask

    task automatic store_reg(input mips_pkg::reg_addr_t rt);
        emit(i_type(mips_pkg::OP_SW, rt, 5'd0, store_off));
        store_off = store_off + 16'd4;
    endtask

    task automatic load_const(input mips_pkg::reg_addr_t rt, input mips_pkg::word_t v);
        emit(i_type(mips_pkg::OP_LUI, rt, 5'd0, v[31:16]));
        emit(i_type(mips_pkg::OP_ORI, rt, rt, v[15:0]));
    endtask

    task automatic build_program();
        mips_pkg::funct_e fns [8];
        mips_pkg::word_t  r1v;
        mips_pkg::word_t  r2v;

        fns = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
        // second round forces opposite signs so slt and sltu disagree
        for (int round = 0; round < 2; round++) begin
            r1v = $urandom;
            r2v = $urandom;
            if (round == 1) begin
                r1v[31] = 1'b0;
                r2v[31] = 1'b1;
            end
            load_const(5'd1, r1v);
            load_const(5'd2, r2v);
            for (int f = 0; f < 8; f++) begin
                emit(r_type(fns[f], 5'd3, 5'd1, 5'd2));
                store_reg(5'd3);
            end
        end

        emit(i_type(mips_pkg::OP_ADDIU, 5'd4, 5'd0, 16'hfffb));
        store_reg(5'd4);
        emit(i_type(mips_pkg::OP_ADDIU, 5'd5, 5'd1, 16'h8000));
        store_reg(5'd5);
        emit(i_type(mips_pkg::OP_ANDI, 5'd6, 5'd1, 16'hf0f0));
        store_reg(5'd6);
        emit(i_type(mips_pkg::OP_ORI, 5'd7, 5'd0, 16'h8001));
        store_reg(5'd7);
        emit(i_type(mips_pkg::OP_XORI, 5'd8, 5'd1, 16'hffff));
        store_reg(5'd8);
        emit(i_type(mips_pkg::OP_LUI, 5'd9, 5'd0, 16'hbeef));
        store_reg(5'd9);

        // dependency distances one, two and three
        emit(i_type(mips_pkg::OP_ADDIU, 5'd10, 5'd0, 16'h0007));
        emit(r_type(mips_pkg::FN_ADDU, 5'd11, 5'd10, 5'd10));
        emit(r_type(mips_pkg::FN_XOR, 5'd12, 5'd11, 5'd10));
        emit(r_type(mips_pkg::FN_OR, 5'd13, 5'd10, 5'd12));
        emit(r_type(mips_pkg::FN_SUBU, 5'd14, 5'd13, 5'd11));
        store_reg(5'd14);
        store_reg(5'd11);
        store_reg(5'd12);
        store_reg(5'd13);

        // load-use on rs, on rt, and straight into a store
        emit(i_type(mips_pkg::OP_SW, 5'd3, 5'd0, 16'h0040));
        emit(i_type(mips_pkg::OP_LW, 5'd15, 5'd0, 16'h0040));
        emit(r_type(mips_pkg::FN_ADDU, 5'd16, 5'd15, 5'd1));
        store_reg(5'd16);
        emit(i_type(mips_pkg::OP_LW, 5'd17, 5'd0, 16'h0040));
        emit(r_type(mips_pkg::FN_SUBU, 5'd18, 5'd2, 5'd17));
        store_reg(5'd18);
        emit(i_type(mips_pkg::OP_LW, 5'd19, 5'd0, 16'h0084));
        store_reg(5'd19);

        emit(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        emit(r_type(mips_pkg::FN_ADDU, 5'd20, 5'd0, 5'd2));
        store_reg(5'd20);
        emit(i_type(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'hffff));
        store_reg(5'd0);
    endtask

    // architectural interpreter without pipeline timing
    function automatic void tb_run_model();
        mips_pkg::word_t     regs [32];
        mips_pkg::word_t     mem [DMEM_WORDS];
        mips_pkg::word_t     instr;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     sext;
        mips_pkg::word_t     zext;
        mips_pkg::word_t     addr;
        mips_pkg::reg_addr_t rt;

        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (int pc = 0; pc < prog_len; pc++) begin
            instr = imem[pc];
            rt    = instr[20:16];
            a     = regs[instr[25:21]];
            b     = regs[rt];
            sext  = {{16{instr[15]}}, instr[15:0]};
            zext  = {16'h0000, instr[15:0]};
            addr  = a + sext;
            case (instr[31:26])
                mips_pkg::OP_SPECIAL: begin
                    case (instr[5:0])
                        mips_pkg::FN_ADDU: regs[instr[15:11]] = a + b;
                        mips_pkg::FN_SUBU: regs[instr[15:11]] = a - b;
                        mips_pkg::FN_AND:  regs[instr[15:11]] = a & b;
                        mips_pkg::FN_OR:   regs[instr[15:11]] = a | b;
                        mips_pkg::FN_XOR:  regs[instr[15:11]] = a ^ b;
                        mips_pkg::FN_NOR:  regs[instr[15:11]] = ~(a | b);
                        mips_pkg::FN_SLT:  regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        mips_pkg::FN_SLTU: regs[instr[15:11]] = (a < b) ? 1 : 0;
                        default: ;
                    endcase
                end
                mips_pkg::OP_ADDIU: regs[rt] = a + sext;
                mips_pkg::OP_ANDI:  regs[rt] = a & zext;
                mips_pkg::OP_ORI:   regs[rt] = a | zext;
                mips_pkg::OP_XORI:  regs[rt] = a ^ zext;
                mips_pkg::OP_LUI:   regs[rt] = {instr[15:0], 16'h0000};
                mips_pkg::OP_LW:    regs[rt] = mem[addr[9:2]];
                mips_pkg::OP_SW: begin
                    mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                default: ;
            endcase
            regs[0] = '0;
        end
    endfunction

    initial begin
        reset_i = 1'b1;
        void'($urandom(32'ha5e1_9c60));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        tb_run_model();
        timeout_limit = 2 * prog_len + 20;

        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            assert (data_sram_wen == 4'h0) else report_failure($sformatf(
                "ERROR: data_sram_wen_o = %h in reset, expected 0", data_sram_wen));
            assert (inst_sram_addr == RESET_PC) else report_failure($sformatf(
                "ERROR: inst_sram_addr_o = %h in reset, expected %h", inst_sram_addr, RESET_PC));
        end
        reset_i = 1'b0;

        forever begin
            @(negedge clk);
            cycles++;
            // no stall can happen before the first load
            if (cycles <= first_lw) begin
                assert (inst_sram_addr == RESET_PC + 32'(4 * cycles))
                    else report_failure($sformatf("ERROR: inst_sram_addr_o = %h, expected %h",
                        inst_sram_addr, RESET_PC + 32'(4 * cycles)));
            end
            assert (cycles < timeout_limit) else report_failure($sformatf(
                "timeout after %0d cycles with %0d of %0d stores seen",
                cycles, seen, exp_addr.size()));
        end
    end

    // store checker
    initial begin
        wait (reset_i === 1'b0);
        while (seen < exp_addr.size()) begin
            @(negedge clk);
            if (data_sram_wen != 4'h0) begin
                assert (data_sram_wen == 4'hf) else report_failure($sformatf(
                    "ERROR: data_sram_wen_o = %h, expected f", data_sram_wen));
                assert (data_sram_addr == exp_addr[seen]) else report_failure($sformatf(
                    "ERROR: data_sram_addr_o = %h, expected %h", data_sram_addr, exp_addr[seen]));
                assert (data_sram_wdata == exp_data[seen]) else report_failure($sformatf(
                    "ERROR: data_sram_wdata_o = %h, expected %h",
                    data_sram_wdata, exp_data[seen]));
                seen++;
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: hdl/mips_top.sv
`timescale 1ns/1ps

module mips_top #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset_i,

    output mips_pkg::word_t inst_sram_addr_o,
    input  mips_pkg::word_t inst_sram_rdata_i,

    output logic [3:0]      data_sram_wen_o,
    output mips_pkg::word_t data_sram_addr_o,
    output mips_pkg::word_t data_sram_wdata_o,
    input  mips_pkg::word_t data_sram_rdata_i
);

    mips_pkg::if_id_t    if_id;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::ex_mem_t   ex_fwd;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::mem_wb_t   mem_fwd;
    mips_pkg::mem_wb_t   mem_wb;
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    logic                stall;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall),
        .inst_sram_addr_o (inst_sram_addr_o),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .if_id_o          (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset_i  (reset_i),
        .if_id_i  (if_id),
        .rs_addr_o(rs_addr),
        .rt_addr_o(rt_addr),
        .rs_data_i(rs_data),
        .rt_data_i(rt_data),
        .ex_fwd_i (ex_fwd),
        .mem_fwd_i(mem_fwd),
        .stall_o  (stall),
        .id_ex_o  (id_ex)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .rs_addr_i(rs_addr),
        .rt_addr_i(rt_addr),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data),
        .wb_i     (mem_wb)
    );

    execute_stage u_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .id_ex_i (id_ex),
        .ex_fwd_o(ex_fwd),
        .ex_mem_o(ex_mem)
    );

    memory_stage u_memory (
        .clk              (clk),
        .reset_i          (reset_i),
        .ex_mem_i         (ex_mem),
        .data_sram_wen_o  (data_sram_wen_o),
        .data_sram_addr_o (data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o),
        .data_sram_rdata_i(data_sram_rdata_i),
        .mem_fwd_o        (mem_fwd),
        .mem_wb_o         (mem_wb)
    );

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  mips_pkg::ex_mem_t ex_mem_i,
    output logic [3:0]        data_sram_wen_o,
    output mips_pkg::word_t   data_sram_addr_o,
    output mips_pkg::word_t   data_sram_wdata_o,
    input  mips_pkg::word_t   data_sram_rdata_i,
    output mips_pkg::mem_wb_t mem_fwd_o,
    output mips_pkg::mem_wb_t mem_wb_o
);

    // word stores use all byte lanes
    assign data_sram_wen_o   = ex_mem_i.mem_write ? 4'hf : 4'h0;
    assign data_sram_addr_o  = ex_mem_i.alu_result;
    assign data_sram_wdata_o = ex_mem_i.store_data;

    always_comb begin
        mem_fwd_o.reg_write = ex_mem_i.reg_write;
        mem_fwd_o.dest      = ex_mem_i.dest;
        mem_fwd_o.result    = ex_mem_i.mem_read ? data_sram_rdata_i : ex_mem_i.alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o <= mem_fwd_o;
        end
    end

    no_read_and_write: assert property (@(posedge clk) disable iff (reset_i)
        !(ex_mem_i.mem_read && ex_mem_i.mem_write))
        else $error("memory stage sees load and store at once");

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  mips_pkg::id_ex_t  id_ex_i,
    output mips_pkg::ex_mem_t ex_fwd_o,
    output mips_pkg::ex_mem_t ex_mem_o
);

    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t alu_result;

    assign a = id_ex_i.operand_a;
    assign b = id_ex_i.operand_b;

    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::ALU_ADD:    alu_result = a + b;
            mips_pkg::ALU_SUB:    alu_result = a - b;
            mips_pkg::ALU_AND:    alu_result = a & b;
            mips_pkg::ALU_OR:     alu_result = a | b;
            mips_pkg::ALU_XOR:    alu_result = a ^ b;
            mips_pkg::ALU_NOR:    alu_result = ~(a | b);
            mips_pkg::ALU_SLT:    alu_result = {31'd0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLTU:   alu_result = {31'd0, a < b};
            mips_pkg::ALU_PASS_B: alu_result = b;
            default:              alu_result = '0;
        endcase
    end

    // also the address for lw/sw
    always_comb begin
        ex_fwd_o.reg_write  = id_ex_i.reg_write;
        ex_fwd_o.mem_read   = id_ex_i.mem_read;
        ex_fwd_o.mem_write  = id_ex_i.mem_write;
        ex_fwd_o.dest       = id_ex_i.dest;
        ex_fwd_o.alu_result = alu_result;
        ex_fwd_o.store_data = id_ex_i.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= ex_fwd_o;
        end
    end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  mips_pkg::reg_addr_t rs_addr_i,
    input  mips_pkg::reg_addr_t rt_addr_i,
    output mips_pkg::word_t     rs_data_o,
    output mips_pkg::word_t     rt_data_o,
    input  mips_pkg::mem_wb_t   wb_i
);

    mips_pkg::word_t regs [32];
    logic            wr_en;

    assign wr_en = wb_i.reg_write && wb_i.dest != '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.dest] <= wb_i.result;
        end
    end

    // writeback in the same cycle is seen by decode
    assign rs_data_o = (wr_en && wb_i.dest == rs_addr_i) ? wb_i.result : regs[rs_addr_i];
    assign rt_data_o = (wr_en && wb_i.dest == rt_addr_i) ? wb_i.result : regs[rt_addr_i];

    zero_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
        (rs_addr_i != '0 || rs_data_o == '0) && (rt_addr_i != '0 || rt_data_o == '0))
        else $error("register zero read back nonzero");

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  mips_pkg::if_id_t    if_id_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    input  mips_pkg::ex_mem_t   ex_fwd_i,
    input  mips_pkg::mem_wb_t   mem_fwd_i,
    output logic                stall_o,
    output mips_pkg::id_ex_t    id_ex_o
);

    typedef enum logic [1:0] {
        SRC_RT,
        SRC_SIGN,
        SRC_ZERO,
        SRC_UPPER
    } src_b_e;

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::reg_addr_t rd_addr;
    logic [15:0]         imm;
    mips_pkg::alu_op_e   alu_op;
    logic                r_valid;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                use_rs;
    logic                use_rt;
    mips_pkg::reg_addr_t dest;
    src_b_e              src_b;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    mips_pkg::word_t     operand_b;
    mips_pkg::id_ex_t    id_ex_d;

    // youngest producer wins over memory and regfile
    function automatic mips_pkg::word_t bypass(
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     rf_data,
        input mips_pkg::ex_mem_t   ex,
        input mips_pkg::mem_wb_t   mem
    );
        if (ex.reg_write && ex.dest == addr) begin
            return ex.alu_result;
        end
        if (mem.reg_write && mem.dest == addr) begin
            return mem.result;
        end
        return rf_data;
    endfunction

    assign opcode    = mips_pkg::opcode_e'(if_id_i.instr[31:26]);
    assign funct     = mips_pkg::funct_e'(if_id_i.instr[5:0]);
    assign rs_addr_o = if_id_i.instr[25:21];
    assign rt_addr_o = if_id_i.instr[20:16];
    assign rd_addr   = if_id_i.instr[15:11];
    assign imm       = if_id_i.instr[15:0];

    always_comb begin
        r_valid   = 1'b0;
        alu_op    = mips_pkg::ALU_ADD;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_rs    = 1'b0;
        use_rt    = 1'b0;
        dest      = rt_addr_o;
        src_b     = SRC_SIGN;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                r_valid = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    default:           r_valid = 1'b0;
                endcase
                dest      = rd_addr;
                src_b     = SRC_RT;
                reg_write = r_valid;
                use_rs    = r_valid;
                use_rt    = r_valid;
            end
            mips_pkg::OP_ADDIU: begin
                reg_write = 1'b1;
                use_rs    = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                // low two opcode bits plus two give and, or and xor
                alu_op    = mips_pkg::alu_op_e'({2'b00, opcode[1:0]} + 4'd2);
                src_b     = SRC_ZERO;
                reg_write = 1'b1;
                use_rs    = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op    = mips_pkg::ALU_PASS_B;
                src_b     = SRC_UPPER;
                reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                use_rs    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                mem_write = 1'b1;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
            end
            default: ;
        endcase

        // r0 never becomes a bypass source
        if (dest == '0) begin
            reg_write = 1'b0;
        end
    end

    assign rs_val = bypass(rs_addr_o, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = bypass(rt_addr_o, rt_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        case (src_b)
            SRC_SIGN:  operand_b = {{16{imm[15]}}, imm};
            SRC_ZERO:  operand_b = {16'h0000, imm};
            SRC_UPPER: operand_b = {imm, 16'h0000};
            default:   operand_b = rt_val;
        endcase
    end

    // a load in execute has no data until next cycle
    assign stall_o = ex_fwd_i.mem_read && ex_fwd_i.reg_write &&
                     ((use_rs && ex_fwd_i.dest == rs_addr_o) ||
                      (use_rt && ex_fwd_i.dest == rt_addr_o));

    always_comb begin
        id_ex_d.alu_op     = alu_op;
        id_ex_d.reg_write  = reg_write;
        id_ex_d.mem_read   = mem_read;
        id_ex_d.mem_write  = mem_write;
        id_ex_d.dest       = dest;
        id_ex_d.operand_a  = rs_val;
        id_ex_d.operand_b  = operand_b;
        id_ex_d.store_data = rt_val;
    end

    always_ff @(posedge clk) begin
        if (reset_i || stall_o) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

    single_stall: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |=> !stall_o)
        else $error("load-use stall held for two cycles");

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stall_i,
    output mips_pkg::word_t   inst_sram_addr_o,
    input  mips_pkg::word_t   inst_sram_rdata_i,
    output mips_pkg::if_id_t  if_id_o
);

    mips_pkg::word_t pc_q;

    assign inst_sram_addr_o = pc_q;

    // the pc only counts up without branches
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // sram data arrives with its pc in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_id_o <= '0;
        end else if (!stall_i) begin
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= inst_sram_rdata_i;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc_q);

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       word_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_NOR    = 4'd5,
        ALU_SLT    = 4'd6,
        ALU_SLTU   = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t dest;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t dest;
        word_t     alu_result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     result;
    } mem_wb_t;

endpackage
